// File: src/mem_cfg_pkg.sv
// Sizing for a 16-entry ROB and a 32-bit word-only memory port; widths here must match the ROB
package mem_cfg_pkg;

	// ==============================
	// ROB sizing
	// ==============================

	// Number of reorder-buffer entries tracked for stomp
	localparam int rob_entries = 16;
	// Width of a ROB index, enough to name every entry
	localparam int rob_id_w = 4;

	// ==============================
	// Memory port sizing
	// ==============================

	// Byte address width of the AXI4-Lite port
	localparam int addr_w = 32;
	// One full word per beat, no partial strobes
	localparam int data_w = 32;

endpackage

// File: src/mem_types_pkg.sv
// Types shared by the memory completion RTL; response codes cover okay and slverr only
package mem_types_pkg;

	import mem_cfg_pkg::*;

	// ==============================
	// Operation and slot state
	// ==============================

	// Kind of memory operation carried by a request
	typedef enum logic {
		op_load  = 1'b0,
		op_store = 1'b1
	} mem_op_t;

	// Slot state machine encoding
	// The store slot only ever walks between idle and wait
	typedef enum logic [1:0] {
		slot_idle   = 2'd0,
		slot_wait   = 2'd1,
		slot_delay  = 2'd2,
		slot_delay2 = 2'd3
	} dram_state_t;

	// One bit per ROB entry, set when the pipeline flushes that entry
	typedef logic [rob_entries-1:0] rob_bitmask_t;

	// ==============================
	// AXI response codes
	// ==============================

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: src/mem_if.sv
// Request and completion handshakes between the router, the slots and the combiner; no clock inside
`timescale 1ns/1ps

// ==============================
// Request from router to a slot
// ==============================

// A request moves when valid and ready are both high
// Ready is high only while the receiving slot is idle
interface mem_req_if import mem_cfg_pkg::*; ();

	logic                valid;
	logic                ready;
	logic [rob_id_w-1:0] id;
	logic [addr_w-1:0]   addr;
	logic [data_w-1:0]   wdata;

	modport source (output valid, id, addr, wdata, input ready);
	modport sink (input valid, id, addr, wdata, output ready);

endinterface

// ==============================
// Completion from a slot to the combiner
// ==============================

// The slot keeps valid and every field stable until it sees ready
interface mem_cpl_if import mem_cfg_pkg::*; ();

	logic                valid;
	logic                ready;
	logic [rob_id_w-1:0] id;
	logic [data_w-1:0]   rdata;
	logic                fault;

	modport source (output valid, id, rdata, fault, input ready);
	modport sink (input valid, id, rdata, fault, output ready);

endinterface

// File: src/issue_router.sv
// One-entry holding stage; a new request is refused while the stage is full or its slot is busy
`timescale 1ns/1ps

module issue_router import mem_cfg_pkg::*; import mem_types_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                req_valid,
	output logic                req_ready,
	input  mem_op_t             req_op,
	input  logic [rob_id_w-1:0] req_id,
	input  logic [addr_w-1:0]   req_addr,
	input  logic [data_w-1:0]   req_wdata,
	mem_req_if.source           ld,
	mem_req_if.source           st
);

	logic                hold_v;
	mem_op_t             hold_op;
	logic [rob_id_w-1:0] hold_id;
	logic [addr_w-1:0]   hold_addr;
	logic [data_w-1:0]   hold_wdata;
	logic                taken;

	// Ready follows the slot that matches the incoming kind
	// The holding stage must be empty as well, so it is never overwritten
	assign req_ready = !hold_v && ((req_op == op_load) ? ld.ready : st.ready);

	// The held request leaves once its slot takes it
	assign taken = (ld.valid && ld.ready) || (st.valid && st.ready);

	always_ff @(posedge clk) begin
		if (rst)
			hold_v <= 1'b0;
		else if (req_valid && req_ready)
			hold_v <= 1'b1;
		else if (taken)
			hold_v <= 1'b0;
	end

	// Fields are captured on acceptance and stay put until the slot takes them
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			hold_op    <= req_op;
			hold_id    <= req_id;
			hold_addr  <= req_addr;
			hold_wdata <= req_wdata;
		end
	end

	// Only the slot of the held kind sees valid
	assign ld.valid = hold_v && (hold_op == op_load);
	assign ld.id    = hold_id;
	assign ld.addr  = hold_addr;
	assign ld.wdata = hold_wdata;

	assign st.valid = hold_v && (hold_op == op_store);
	assign st.id    = hold_id;
	assign st.addr  = hold_addr;
	assign st.wdata = hold_wdata;

endmodule

// File: src/load_slot.sv
// Single outstanding load; completion appears two cycles after the R beat and any nonzero RRESP faults
`timescale 1ns/1ps

module load_slot import mem_cfg_pkg::*; import mem_types_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	mem_req_if.sink           req,
	mem_cpl_if.source         cpl,
	output logic [addr_w-1:0] araddr,
	output logic              arvalid,
	input  logic              arready,
	input  logic [data_w-1:0] rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready
);

	dram_state_t state;
	logic        take;
	logic        r_hs;

	// The slot takes a new load only from idle
	assign req.ready = (state == slot_idle);
	assign take      = req.valid && req.ready;

	// Read data is only expected while waiting, but ready also stays up in idle
	assign rready = (state == slot_idle) || (state == slot_wait);
	assign r_hs   = rvalid && rready && (state == slot_wait);

	// ==============================
	// Slot state machine
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= slot_idle;
			arvalid   <= 1'b0;
			cpl.valid <= 1'b0;
		end else begin
			case (state)
				slot_idle: begin
					// Address goes out the cycle after the request is taken
					if (take) begin
						state   <= slot_wait;
						arvalid <= 1'b1;
					end
				end
				slot_wait: begin
					// Drop the address once the slave has it
					if (arvalid && arready)
						arvalid <= 1'b0;
					if (r_hs)
						state <= slot_delay;
				end
				slot_delay: begin
					// First settling cycle for forwarding
					state <= slot_delay2;
				end
				slot_delay2: begin
					// Present the completion, then hold it until the combiner takes it
					if (!cpl.valid) begin
						cpl.valid <= 1'b1;
					end else if (cpl.ready) begin
						cpl.valid <= 1'b0;
						state     <= slot_idle;
					end
				end
				default: state <= slot_idle;
			endcase
		end
	end

	// ==============================
	// Payload capture
	// ==============================

	// Address and index come from the request, data and fault from the R beat
	always_ff @(posedge clk) begin
		if (take) begin
			araddr <= req.addr;
			cpl.id <= req.id;
		end
		if (r_hs) begin
			cpl.rdata <= rdata;
			cpl.fault <= (rresp != resp_okay);
		end
	end

endmodule

// File: src/store_slot.sv
// Single outstanding store; done is reported before the B response, so a B error is only sticky
`timescale 1ns/1ps

module store_slot import mem_cfg_pkg::*; import mem_types_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	mem_req_if.sink           req,
	mem_cpl_if.source         cpl,
	output logic [addr_w-1:0] awaddr,
	output logic              awvalid,
	input  logic              awready,
	output logic [data_w-1:0] wdata,
	output logic              wvalid,
	input  logic              wready,
	input  logic [1:0]        bresp,
	input  logic              bvalid,
	output logic              bready,
	output logic              store_error
);

	dram_state_t state;
	logic        take;
	// Per-channel progress of the store in flight
	logic        aw_ok;
	logic        w_ok;
	logic        b_ok;
	logic        cpl_sent;
	// Progress including a handshake in this very cycle
	logic        aw_now;
	logic        w_now;
	logic        b_now;
	logic        cpl_hs;

	assign req.ready = (state == slot_idle);
	assign take      = req.valid && req.ready;

	assign aw_now = aw_ok || (awvalid && awready);
	assign w_now  = w_ok || (wvalid && wready);
	assign bready = !b_ok;
	assign b_now  = b_ok || (bvalid && bready);
	assign cpl_hs = cpl.valid && cpl.ready;

	// A store carries no read data and reports errors through store_error
	assign cpl.rdata = '0;
	assign cpl.fault = 1'b0;

	// ==============================
	// Slot state machine
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= slot_idle;
			awvalid     <= 1'b0;
			wvalid      <= 1'b0;
			aw_ok       <= 1'b0;
			w_ok        <= 1'b0;
			b_ok        <= 1'b0;
			cpl_sent    <= 1'b0;
			cpl.valid   <= 1'b0;
			store_error <= 1'b0;
		end else begin
			// The store has already retired, so an error can only be flagged
			if (bvalid && bready && bresp == resp_slverr)
				store_error <= 1'b1;
			case (state)
				slot_idle: begin
					// Address and data go out together
					if (take) begin
						state   <= slot_wait;
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
					end
				end
				slot_wait: begin
					if (awvalid && awready) begin
						awvalid <= 1'b0;
						aw_ok   <= 1'b1;
					end
					if (wvalid && wready) begin
						wvalid <= 1'b0;
						w_ok   <= 1'b1;
					end
					if (bvalid && bready)
						b_ok <= 1'b1;
					// Done is raised once both channels are through, without waiting for B
					if (aw_now && w_now && !cpl.valid && !cpl_sent)
						cpl.valid <= 1'b1;
					if (cpl_hs) begin
						cpl.valid <= 1'b0;
						cpl_sent  <= 1'b1;
					end
					// Free the slot when B is in and the completion has gone
					if (b_now && (cpl_sent || cpl_hs)) begin
						state    <= slot_idle;
						aw_ok    <= 1'b0;
						w_ok     <= 1'b0;
						b_ok     <= 1'b0;
						cpl_sent <= 1'b0;
					end
				end
				default: state <= slot_idle;
			endcase
		end
	end

	// Payload is latched on take and held for the whole store
	always_ff @(posedge clk) begin
		if (take) begin
			awaddr <= req.addr;
			wdata  <= req.wdata;
			cpl.id <= req.id;
		end
	end

endmodule

// File: src/mem_done.sv
// Load completions always win a tie; the ROB has no back-pressure so done is a one-cycle pulse
`timescale 1ns/1ps

module mem_done import mem_cfg_pkg::*; import mem_types_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	mem_cpl_if.sink             ld,
	mem_cpl_if.sink             st,
	input  rob_bitmask_t        stomp,
	output logic                done_valid,
	output logic [rob_id_w-1:0] done_id,
	output logic [data_w-1:0]   done_data,
	output logic                done_fault
);

	logic                sel_v;
	logic [rob_id_w-1:0] sel_id;
	logic [data_w-1:0]   sel_data;
	logic                sel_fault;

	// ==============================
	// Arbitration
	// ==============================

	// Loads are always taken, a store waits while a load is present
	assign ld.ready = 1'b1;
	assign st.ready = !ld.valid;

	// Pick the completion accepted this cycle
	always_comb begin
		sel_v = ld.valid || st.valid;
		if (ld.valid) begin
			sel_id    = ld.id;
			sel_data  = ld.rdata;
			sel_fault = ld.fault;
		end else begin
			sel_id    = st.id;
			sel_data  = st.rdata;
			sel_fault = st.fault;
		end
	end

	// ==============================
	// Done report
	// ==============================

	// A stomped entry is consumed here and never reported
	always_ff @(posedge clk) begin
		if (rst)
			done_valid <= 1'b0;
		else
			done_valid <= sel_v && !stomp[sel_id];
	end

	always_ff @(posedge clk) begin
		done_id    <= sel_id;
		done_data  <= sel_data;
		done_fault <= sel_fault;
	end

endmodule

// File: src/mem_done_unit.sv
// Memory completion unit with one load and one store in flight at most; full-word AXI4-Lite only
`timescale 1ns/1ps

module mem_done_unit import mem_cfg_pkg::*; import mem_types_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	// Issued memory operations
	input  logic                req_valid,
	output logic                req_ready,
	input  mem_op_t             req_op,
	input  logic [rob_id_w-1:0] req_id,
	input  logic [addr_w-1:0]   req_addr,
	input  logic [data_w-1:0]   req_wdata,
	// Flushed ROB entries
	input  rob_bitmask_t        stomp,
	// AXI4-Lite read channels
	output logic [addr_w-1:0]   araddr,
	output logic                arvalid,
	input  logic                arready,
	input  logic [data_w-1:0]   rdata,
	input  logic [1:0]          rresp,
	input  logic                rvalid,
	output logic                rready,
	// AXI4-Lite write channels
	output logic [addr_w-1:0]   awaddr,
	output logic                awvalid,
	input  logic                awready,
	output logic [data_w-1:0]   wdata,
	output logic                wvalid,
	input  logic                wready,
	input  logic [1:0]          bresp,
	input  logic                bvalid,
	output logic                bready,
	// Completion report to the ROB
	output logic                done_valid,
	output logic [rob_id_w-1:0] done_id,
	output logic [data_w-1:0]   done_data,
	output logic                done_fault,
	output logic                store_error
);

	mem_req_if ld_req ();
	mem_req_if st_req ();
	mem_cpl_if ld_cpl ();
	mem_cpl_if st_cpl ();

	issue_router i_issue_router (
		.clk, .rst, .req_valid, .req_ready, .req_op, .req_id, .req_addr, .req_wdata,
		.ld(ld_req), .st(st_req)
	);

	load_slot i_load_slot (
		.clk, .rst, .req(ld_req), .cpl(ld_cpl),
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
	);

	store_slot i_store_slot (
		.clk, .rst, .req(st_req), .cpl(st_cpl),
		.awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready, .store_error
	);

	mem_done i_mem_done (
		.clk, .rst, .ld(ld_cpl), .st(st_cpl), .stomp,
		.done_valid, .done_id, .done_data, .done_fault
	);

endmodule

// File: verif/mem_done_properties.sv
// Bound checks on reset values, load timing and stomp filtering; needs --assert
`timescale 1ns/1ps

module mem_done_properties import mem_cfg_pkg::*; import mem_types_pkg::*; (
	input logic                clk,
	input logic                rst,
	input logic                req_valid,
	input logic                req_ready,
	input mem_op_t             req_op,
	input logic [rob_id_w-1:0] req_id,
	input rob_bitmask_t        stomp,
	input logic                arvalid,
	input logic                awvalid,
	input logic                wvalid,
	input logic                rvalid,
	input logic                rready,
	input logic                bready,
	input logic                done_valid,
	input logic [rob_id_w-1:0] done_id,
	input logic                store_error
);

	logic [rob_id_w-1:0] load_id;
	// Set for an index whose stomp bit has stayed high since its request was accepted
	rob_bitmask_t        held_stomp;
	// Number of assertion failures so far
	int                  fail_count;

	// Index of the load in flight
	always_ff @(posedge clk) begin
		if (req_valid && req_ready && req_op == op_load)
			load_id <= req_id;
	end

	// A bit starts from the stomp state at acceptance and drops once stomp lets go
	always_ff @(posedge clk) begin
		if (rst) begin
			held_stomp <= '0;
		end else begin
			held_stomp <= held_stomp & stomp;
			if (req_valid && req_ready)
				held_stomp[req_id] <= stomp[req_id];
		end
	end

	// ==============================
	// Reset and stomp rules
	// ==============================

	reset_values: assert property (@(posedge clk)
		rst |=> (!done_valid && !arvalid && !awvalid && !wvalid && !store_error &&
			req_ready && rready && bready))
		else begin
			$error("outputs are not at their reset values after reset");
			fail_count++;
		end

	// An index stomped from acceptance up to its completion never comes out
	stomp_blocks_done: assert property (@(posedge clk) disable iff (rst)
		done_valid |-> !held_stomp[done_id])
		else begin
			$error("done reported for a stomped ROB index");
			fail_count++;
		end

	// ==============================
	// Load timing
	// ==============================

	// An unstomped load reports done four cycles after its R beat, stores never delay it
	load_done_latency: assert property (@(posedge clk) disable iff (rst)
		(rvalid && rready && !stomp[load_id]) |-> ##4 (done_valid && done_id == load_id))
		else begin
			$error("load done did not follow its R beat by four cycles");
			fail_count++;
		end

endmodule

bind mem_done_unit mem_done_properties i_mem_done_properties (
	.clk, .rst, .req_valid, .req_ready, .req_op, .req_id, .stomp,
	.arvalid, .awvalid, .wvalid, .rvalid, .rready, .bready,
	.done_valid, .done_id, .store_error
);

// File: verif/tb_mem_done_unit.sv
// Drives mem_done_unit against a 256-word AXI4-Lite memory model; bytes 0x3c0 to 0x3ff answer slverr
`timescale 1ns/1ps

module tb_mem_done_unit;

	import mem_cfg_pkg::*;
	import mem_types_pkg::*;

	localparam int          done_timeout = 200;
	localparam int          hs_timeout   = 100;
	localparam int          run_limit    = 20000;
	localparam int          pair_count   = 6;
	localparam logic [31:0] fill_pattern = 32'h5a3c_96e1;
	localparam logic [31:0] fault_base   = 32'h0000_03c0;
	localparam logic [31:0] fault_mask   = 32'hffff_ffc0;

	logic                clk;
	logic                rst;
	logic                req_valid;
	logic                req_ready;
	mem_op_t             req_op;
	logic [rob_id_w-1:0] req_id;
	logic [addr_w-1:0]   req_addr;
	logic [data_w-1:0]   req_wdata;
	rob_bitmask_t        stomp;
	logic [addr_w-1:0]   araddr;
	logic                arvalid;
	logic                arready;
	logic [data_w-1:0]   rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rready;
	logic [addr_w-1:0]   awaddr;
	logic                awvalid;
	logic                awready;
	logic [data_w-1:0]   wdata;
	logic                wvalid;
	logic                wready;
	logic [1:0]          bresp;
	logic                bvalid;
	logic                bready;
	logic                done_valid;
	logic [rob_id_w-1:0] done_id;
	logic [data_w-1:0]   done_data;
	logic                done_fault;
	logic                store_error;

	integer      seed = 32'h88b2_b9bc;
	// Memory behind the AXI port and the copy the expected values come from
	logic [31:0] model_mem [256];
	logic [31:0] shadow_mem [256];
	// Expected completion per ROB index, filled at issue
	int          expected_count [16];
	int          seen_count [16];
	logic        exp_fault [16];
	logic        exp_check [16];
	logic [31:0] exp_data [16];
	// Each process keeps its own error count
	int          errors;
	int          cmp_errors;
	int          rd_errors;
	int          wr_errors;
	int          checks;
	int          ties;
	int          r_beats;
	int          tests_run;
	int          tests_failed;
	logic        tie_armed;
	// Index of the most recent load, which must win a tie
	logic [3:0]  inflight_load;

	mem_done_unit i_mem_done_unit (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==============================
	// Helpers and reference model
	// ==============================

	function automatic logic [31:0] fill_word(input int index);
		return (index << 2) ^ fill_pattern;
	endfunction

	function automatic logic in_fault_range(input logic [31:0] addr);
		return (addr & fault_mask) == fault_base;
	endfunction

	function automatic int random_gap(input int max);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[15:0]) % (max + 1);
	endfunction

	function automatic logic random_bit();
		logic [31:0] r;
		r = $random(seed);
		return r[0];
	endfunction

	// Expected {fault, data} of a done report, taken from the shadow memory
	function automatic logic [32:0] ref_done(input mem_op_t op, input logic [31:0] addr);
		logic        fault;
		logic [31:0] data;
		fault = (op == op_load) && in_fault_range(addr);
		data  = (op == op_load) ? shadow_mem[addr[9:2]] : 32'h0;
		return {fault, data};
	endfunction

	function automatic int all_errors();
		return errors + cmp_errors + rd_errors + wr_errors +
			i_mem_done_unit.i_mem_done_properties.fail_count;
	endfunction

	task automatic check_bit(input string name, input logic got, input logic want);
		assert (got === want) else begin
			$display("error at %0t: %s expected %b got %b", $time, name, want, got);
			errors++;
		end
	endtask

	// Records the expected done, then holds the request until req_ready is seen
	task automatic issue_op(input mem_op_t op, input logic [3:0] id, input logic [31:0] addr,
			input logic [31:0] data, input logic stomped);
		logic [32:0] exp;
		int          waited;
		exp = ref_done(op, addr);
		if (!stomped) begin
			expected_count[id]++;
			exp_fault[id] = exp[32];
			exp_data[id]  = exp[31:0];
			exp_check[id] = (op == op_load) && !exp[32];
		end
		if (op == op_load)
			inflight_load = id;
		if (op == op_store && !in_fault_range(addr))
			shadow_mem[addr[9:2]] = data;
		@(negedge clk);
		req_valid = 1'b1;
		req_op    = op;
		req_id    = id;
		req_addr  = addr;
		req_wdata = data;
		waited    = 0;
		// req_ready is combinational from req_op, so look once it has settled
		#1;
		while (!req_ready && waited < hs_timeout) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (!req_ready) begin
			$display("request for index %0d was never accepted", id);
			errors++;
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_done(input logic [3:0] id);
		int waited;
		waited = 0;
		while (seen_count[id] < expected_count[id] && waited < done_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (seen_count[id] < expected_count[id]) begin
			$display("no done report for index %0d within %0d cycles", id, done_timeout);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (all_errors() == errs_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				all_errors() - errs_before);
		end
	endtask

	// ==============================
	// AXI4-Lite memory model
	// ==============================

	initial begin : read_port
		logic [31:0] rd_addr;
		int          waited;
		arready = 1'b0;
		rvalid  = 1'b0;
		rdata   = 32'h0;
		rresp   = resp_okay;
		forever begin
			@(negedge clk);
			if (!rst && arvalid) begin
				repeat (random_gap(3)) @(negedge clk);
				// Handshake lands on the next rising edge
				arready = 1'b1;
				rd_addr = araddr;
				@(negedge clk);
				arready = 1'b0;
				repeat (random_gap(4)) @(negedge clk);
				rdata  = model_mem[rd_addr[9:2]];
				rresp  = in_fault_range(rd_addr) ? resp_slverr : resp_okay;
				rvalid = 1'b1;
				waited = 0;
				while (!rready && waited < hs_timeout) begin
					@(negedge clk);
					waited++;
				end
				if (!rready) begin
					$display("read data was never accepted by the load slot");
					rd_errors++;
				end
				@(negedge clk);
				rvalid = 1'b0;
				r_beats++;
			end
		end
	end

	initial begin : write_port
		logic [31:0] wr_addr;
		logic [31:0] wr_data;
		logic        got_aw;
		logic        got_w;
		int          waited;
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		bresp   = resp_okay;
		for (int i = 0; i < 256; i++)
			model_mem[i] = fill_word(i);
		forever begin
			@(negedge clk);
			if (!rst && (awvalid || wvalid)) begin
				got_aw = 1'b0;
				got_w  = 1'b0;
				waited = 0;
				// Address and data are accepted on independent random cycles
				while (!(got_aw && got_w) && waited < hs_timeout) begin
					awready = awvalid && !got_aw && random_bit();
					wready  = wvalid && !got_w && random_bit();
					if (awready) begin
						wr_addr = awaddr;
						got_aw  = 1'b1;
					end
					if (wready) begin
						wr_data = wdata;
						got_w   = 1'b1;
					end
					@(negedge clk);
					waited++;
				end
				awready = 1'b0;
				wready  = 1'b0;
				if (!(got_aw && got_w)) begin
					$display("write address or data never reached the memory model");
					wr_errors++;
				end else if (!in_fault_range(wr_addr)) begin
					model_mem[wr_addr[9:2]] = wr_data;
				end
				repeat (random_gap(3)) @(negedge clk);
				bresp  = in_fault_range(wr_addr) ? resp_slverr : resp_okay;
				bvalid = 1'b1;
				waited = 0;
				while (!bready && waited < hs_timeout) begin
					@(negedge clk);
					waited++;
				end
				if (!bready) begin
					$display("write response was never accepted by the store slot");
					wr_errors++;
				end
				@(negedge clk);
				bvalid = 1'b0;
			end
		end
	end

	// ==============================
	// Done report checker
	// ==============================

	always @(negedge clk) begin : compare_done
		if (!rst && done_valid) begin
			checks++;
			assert (seen_count[done_id] < expected_count[done_id]) else begin
				$display("done at %0t for index %0d, which has no completion outstanding",
					$time, done_id);
				cmp_errors++;
			end
			if (seen_count[done_id] < expected_count[done_id]) begin
				seen_count[done_id]++;
				assert (done_fault == exp_fault[done_id]) else begin
					$display("error at %0t: done_fault expected %b got %b", $time,
						exp_fault[done_id], done_fault);
					cmp_errors++;
				end
				if (exp_check[done_id]) begin
					assert (done_data == exp_data[done_id]) else begin
						$display("error at %0t: done_data expected %h got %h", $time,
							exp_data[done_id], done_data);
						cmp_errors++;
					end
				end
			end
			// Both completions were waiting last cycle so the load must come out first
			if (tie_armed) begin
				assert (done_id == inflight_load) else begin
					$display("error at %0t: done_id expected %0d got %0d", $time,
						inflight_load, done_id);
					cmp_errors++;
				end
			end
		end
		tie_armed = !rst && i_mem_done_unit.ld_cpl.valid && i_mem_done_unit.st_cpl.valid;
		if (tie_armed)
			ties++;
	end

	initial begin : watchdog
		repeat (run_limit) @(posedge clk);
		$display("simulation ran past %0d cycles without finishing", run_limit);
		$display("*** FAILED ***");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin : main
		logic [3:0]  ld_id;
		logic [3:0]  st_id;
		logic [31:0] ld_addr;
		logic [31:0] st_addr;
		logic [31:0] st_data;
		int          errs_before;
		int          waited;
		int          beats;
		rst       = 1'b1;
		req_valid = 1'b0;
		req_op    = op_load;
		req_id    = '0;
		req_addr  = '0;
		req_wdata = '0;
		stomp     = '0;
		for (int i = 0; i < 256; i++)
			shadow_mem[i] = fill_word(i);
		repeat (8) @(negedge clk);
		rst = 1'b0;

		errs_before = all_errors();
		@(negedge clk);
		check_bit("done_valid", done_valid, 1'b0);
		check_bit("arvalid", arvalid, 1'b0);
		check_bit("awvalid", awvalid, 1'b0);
		check_bit("wvalid", wvalid, 1'b0);
		check_bit("store_error", store_error, 1'b0);
		check_bit("req_ready", req_ready, 1'b1);
		end_test("reset state", errs_before);

		errs_before = all_errors();
		issue_op(op_load, 4'd1, 32'h0000_0040, 32'h0, 1'b0);
		wait_done(4'd1);
		end_test("single load", errs_before);

		errs_before = all_errors();
		issue_op(op_store, 4'd2, 32'h0000_0080, 32'hc0ff_ee11, 1'b0);
		wait_done(4'd2);
		issue_op(op_load, 4'd3, 32'h0000_0080, 32'h0, 1'b0);
		wait_done(4'd3);
		check_bit("store_error", store_error, 1'b0);
		end_test("store then load back", errs_before);

		errs_before = all_errors();
		issue_op(op_load, 4'd4, 32'h0000_03c4, 32'h0, 1'b0);
		wait_done(4'd4);
		issue_op(op_store, 4'd5, 32'h0000_03c8, 32'h1234_5678, 1'b0);
		wait_done(4'd5);
		// B arrives after the store has already reported done
		waited = 0;
		while (!store_error && waited < done_timeout) begin
			@(negedge clk);
			waited++;
		end
		check_bit("store_error", store_error, 1'b1);
		end_test("fault range", errs_before);

		// Loads stay in the lower half and stores in the upper half, so they never alias
		errs_before = all_errors();
		for (int i = 0; i < pair_count; i++) begin
			ld_id   = 4'(2 * i);
			st_id   = 4'(2 * i + 1);
			ld_addr = random_gap(127) << 2;
			st_addr = (128 + random_gap(111)) << 2;
			st_data = $random(seed);
			issue_op(op_load, ld_id, ld_addr, 32'h0, 1'b0);
			repeat (random_gap(2)) @(negedge clk);
			issue_op(op_store, st_id, st_addr, st_data, 1'b0);
			wait_done(ld_id);
			wait_done(st_id);
		end
		end_test("load and store in flight", errs_before);

		errs_before = all_errors();
		stomp     = '0;
		stomp[12] = 1'b1;
		beats     = r_beats;
		issue_op(op_load, 4'd12, 32'h0000_0100, 32'h0, 1'b1);
		issue_op(op_store, 4'd13, 32'h0000_0200, 32'h0bad_f00d, 1'b0);
		wait_done(4'd13);
		waited = 0;
		while (r_beats == beats && waited < done_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (r_beats == beats) begin
			$display("stomped load never received its read data");
			errors++;
		end
		// Keep the flush up until the stomped completion has drained
		repeat (6) @(negedge clk);
		stomp = '0;
		end_test("stomped load", errs_before);

		repeat (10) @(negedge clk);
		for (int i = 0; i < 16; i++) begin
			if (seen_count[i] != expected_count[i]) begin
				$display("index %0d expected %0d done reports, saw %0d", i, expected_count[i],
					seen_count[i]);
				errors++;
			end
		end
		$display("tests run %0d, failed %0d, done reports %0d, ties %0d, errors %0d",
			tests_run, tests_failed, checks, ties, all_errors());
		if (all_errors() == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: files.f
src/mem_cfg_pkg.sv
src/mem_types_pkg.sv
src/mem_if.sv
src/issue_router.sv
src/load_slot.sv
src/store_slot.sv
src/mem_done.sv
src/mem_done_unit.sv
verif/mem_done_properties.sv
verif/tb_mem_done_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the memory completion testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_mem_done_unit \
	--Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '*** PASSED ***'; then
	exit 0
fi
exit 1
